// ==== stream_sink_pkg.sv ====
/*
 * Shared types of the store streamer.
 * Holds the word width, the stream lane and store request structs,
 * the control and flag bundles and the state encoding of the sink FSM.
 */

`default_nettype none

package stream_sink_pkg;

  // Every memory port carries one word of this width; other widths are not supported.
  localparam int unsigned WORD_WIDTH = 32;

  // One lane of an incoming beat.
  typedef struct packed {
    logic [WORD_WIDTH-1:0]   data; // Payload word.
    logic [WORD_WIDTH/8-1:0] strb; // Byte strobe with one bit per byte of data.
  } stream_word_t;

  // One store request on a memory port. The ports only write and carry no wen field.
  typedef struct packed {
    logic                    req;  // Request is pending.
    logic [31:0]             addr; // Word-aligned byte address.
    logic [WORD_WIDTH-1:0]   data; // Word to be written.
    logic [WORD_WIDTH/8-1:0] be;   // Byte enables.
  } tcdm_req_t;

  // Two-dimensional transfer pattern.
  typedef struct packed {
    logic [31:0] base_addr;   // Address of the first beat.
    logic [15:0] trans_size;  // Total number of beats in the transfer.
    logic [15:0] line_length; // Beats per line.
    logic [31:0] line_stride; // Byte distance between the starts of two lines.
  } addressgen_ctrl_t;

  // Control bundle coming from the engine controller.
  typedef struct packed {
    logic             req_start;       // Start request sampled while ready_start is high.
    addressgen_ctrl_t addressgen_ctrl; // Pattern loaded at start.
  } ctrl_sink_t;

  // Status flags going back to the controller.
  typedef struct packed {
    logic ready_start; // High while the sink is idle and can take a start.
    logic done;        // One-cycle pulse at the end of a transfer.
    logic in_progress; // Address generator still has beats to count.
  } flags_sink_t;

  // States of the sink control FSM.
  typedef enum logic {
    SINK_IDLE    = 1'b0,
    SINK_WORKING = 1'b1
  } sink_state_e;

endpackage

`default_nettype wire

// ==== stream_addressgen.sv ====
/*
 * Two-dimensional address generator.
 * Produces the byte address of the current beat and counts
 * accepted beats until the programmed transfer size is reached.
 */

`timescale 1ns/10ps
`default_nettype none

module stream_addressgen #(
  parameter int unsigned NB_TCDM_PORTS = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              clear_i,
  input  logic                              load_i,
  input  logic                              enable_i,
  input  stream_sink_pkg::addressgen_ctrl_t ctrl_i,
  output logic [31:0]                       addr_o,
  output logic                              in_progress_o
);

  import stream_sink_pkg::*;

  // A beat covers one word per port, so consecutive beats in a line are this far apart.
  localparam logic [31:0] BEAT_STEP = 32'(NB_TCDM_PORTS * WORD_WIDTH / 8);

  logic [15:0] trans_size_q;  // Copy of the pattern taken on load.
  logic [15:0] line_length_q;
  logic [31:0] line_stride_q;

  logic [15:0] beat_cnt_q;    // Beats accepted since load.
  logic [15:0] line_cnt_q;    // Beat index inside the current line.
  logic [31:0] word_offs_q;   // Byte offset of the current beat inside its line.
  logic [31:0] line_base_q;   // Start address of the current line.
  logic        in_progress_q;

  logic last_in_line;
  logic last_beat;

  assign last_in_line = (line_cnt_q == line_length_q - 16'd1);
  assign last_beat    = (beat_cnt_q == trans_size_q - 16'd1);

  // The address is valid combinationally for the beat that is about to be taken.
  assign addr_o        = line_base_q + word_offs_q;
  assign in_progress_o = in_progress_q;

  // Pattern registers only change on load.
  always_ff @(posedge clk_i) begin
    if (load_i) begin
      trans_size_q  <= ctrl_i.trans_size;
      line_length_q <= ctrl_i.line_length;
      line_stride_q <= ctrl_i.line_stride;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q    <= '0;
      line_cnt_q    <= '0;
      word_offs_q   <= '0;
      line_base_q   <= '0;
      in_progress_q <= 1'b0;
    end else if (clear_i) begin
      beat_cnt_q    <= '0;
      line_cnt_q    <= '0;
      word_offs_q   <= '0;
      line_base_q   <= '0;
      in_progress_q <= 1'b0;
    end else if (load_i) begin
      beat_cnt_q    <= '0;
      line_cnt_q    <= '0;
      word_offs_q   <= '0;
      line_base_q   <= ctrl_i.base_addr;
      in_progress_q <= (ctrl_i.trans_size != 16'd0); // An empty transfer ends at once.
    end else if (enable_i && in_progress_q) begin
      beat_cnt_q <= beat_cnt_q + 16'd1;
      if (last_beat) begin
        in_progress_q <= 1'b0; // Final beat of the transfer has been taken.
      end
      if (last_in_line) begin
        // Wrap to the start of the next line.
        line_cnt_q  <= '0;
        word_offs_q <= '0;
        line_base_q <= line_base_q + line_stride_q;
      end else begin
        line_cnt_q  <= line_cnt_q + 16'd1;
        word_offs_q <= word_offs_q + BEAT_STEP;
      end
    end
  end

endmodule

`default_nettype wire

// ==== beat_splitter.sv ====
/*
 * Beat splitter.
 * Breaks each accepted beat into one store request register per port,
 * so that the ports drain independently of each other.
 */

`timescale 1ns/10ps
`default_nettype none

module beat_splitter #(
  parameter int unsigned NB_TCDM_PORTS = 2
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic                         clear_i,
  input  stream_sink_pkg::stream_word_t beat_i [NB_TCDM_PORTS],
  input  logic                         beat_valid_i,
  output logic                         beat_ready_o,
  input  logic [31:0]                  addr_i,
  output stream_sink_pkg::tcdm_req_t   lane_o [NB_TCDM_PORTS],
  input  logic [NB_TCDM_PORTS-1:0]     lane_gnt_i,
  output logic                         busy_o
);

  import stream_sink_pkg::*;

  logic [NB_TCDM_PORTS-1:0] lane_req_q;                 // Lane holds a pending store.
  logic [31:0]              lane_addr_q [NB_TCDM_PORTS]; // Address of the store in each lane.
  logic [WORD_WIDTH-1:0]    lane_data_q [NB_TCDM_PORTS];
  logic [WORD_WIDTH/8-1:0]  lane_be_q   [NB_TCDM_PORTS];
  logic [NB_TCDM_PORTS-1:0] lane_free;                   // Lane is empty or emptying now.
  logic                     beat_take;

  // A new beat may enter only when every lane can make room in this cycle.
  assign lane_free    = ~lane_req_q | lane_gnt_i;
  assign beat_ready_o = &lane_free;
  assign beat_take    = beat_valid_i & beat_ready_o;
  assign busy_o       = |lane_req_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_req_q <= '0;
    end else if (clear_i) begin
      lane_req_q <= '0;
    end else if (beat_take) begin
      lane_req_q <= '1;                      // All lanes fill together.
    end else begin
      lane_req_q <= lane_req_q & ~lane_gnt_i; // Each lane drops on its own grant.
    end
  end

  always_ff @(posedge clk_i) begin
    if (beat_take) begin
      for (int p = 0; p < NB_TCDM_PORTS; p++) begin
        lane_addr_q[p] <= addr_i + 32'(p * WORD_WIDTH / 8); // Word p sits 4*p bytes in.
        lane_data_q[p] <= beat_i[p].data;
        lane_be_q[p]   <= beat_i[p].strb;
      end
    end
  end

  always_comb begin
    for (int p = 0; p < NB_TCDM_PORTS; p++) begin
      lane_o[p].req  = lane_req_q[p];
      lane_o[p].addr = lane_addr_q[p];
      lane_o[p].data = lane_data_q[p];
      lane_o[p].be   = lane_be_q[p];
    end
  end

endmodule

`default_nettype wire

// ==== tcdm_store_fifo.sv ====
/*
 * Store request FIFO for one memory port.
 * Decouples a splitter lane from the memory request port.
 * A depth of 0 connects the lane straight to the port.
 */

`timescale 1ns/10ps
`default_nettype none

module tcdm_store_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  stream_sink_pkg::tcdm_req_t push_i,
  output logic                       push_gnt_o,
  output stream_sink_pkg::tcdm_req_t pop_o,
  input  logic                       pop_gnt_i,
  output logic                       empty_o
);

  import stream_sink_pkg::*;

  if (FIFO_DEPTH == 0) begin : gen_bypass
    // Without storage the lane sees the memory grant directly.
    assign pop_o      = push_i;
    assign push_gnt_o = pop_gnt_i;
    assign empty_o    = 1'b1;
  end else begin : gen_fifo
    localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
    localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

    logic [31:0]             addr_mem [FIFO_DEPTH]; // Address of each held store.
    logic [WORD_WIDTH-1:0]   data_mem [FIFO_DEPTH];
    logic [WORD_WIDTH/8-1:0] be_mem   [FIFO_DEPTH];
    logic [PTR_W-1:0]        wr_ptr_q;
    logic [PTR_W-1:0]        rd_ptr_q;
    logic [CNT_W-1:0]        cnt_q;    // Number of stores held.
    logic                    full;
    logic                    empty;
    logic                    push;
    logic                    pop;

    assign full  = (cnt_q == FULL_CNT);
    assign empty = (cnt_q == '0);
    assign push  = push_i.req & ~full;
    assign pop   = pop_gnt_i & ~empty;

    assign push_gnt_o = ~full; // The lane may hand over a store whenever there is room.
    assign empty_o    = empty;

    assign pop_o.req  = ~empty;
    assign pop_o.addr = addr_mem[rd_ptr_q];
    assign pop_o.data = data_mem[rd_ptr_q];
    assign pop_o.be   = be_mem[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else if (clear_i) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1; // Wrap around.
        end
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push && !pop) begin
          cnt_q <= cnt_q + 1'b1;
        end else if (pop && !push) begin
          cnt_q <= cnt_q - 1'b1;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (push) begin
        addr_mem[wr_ptr_q] <= push_i.addr;
        data_mem[wr_ptr_q] <= push_i.data;
        be_mem[wr_ptr_q]   <= push_i.be;
      end
    end
  end

endmodule

`default_nettype wire

// ==== stream_sink.sv ====
/*
 * Store streamer top level.
 * Takes wide beats from an engine, stamps each word with a generated
 * address and issues one store per memory port through per-port FIFOs.
 * A small FSM handles start, drain and the done pulse.
 */

`timescale 1ns/10ps
`default_nettype none

module stream_sink #(
  parameter int unsigned NB_TCDM_PORTS   = 2,
  parameter int unsigned TCDM_FIFO_DEPTH = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  stream_sink_pkg::ctrl_sink_t   ctrl_i,
  output stream_sink_pkg::flags_sink_t  flags_o,
  input  stream_sink_pkg::stream_word_t stream_i [NB_TCDM_PORTS],
  input  logic                          stream_valid_i,
  output logic                          stream_ready_o,
  output stream_sink_pkg::tcdm_req_t    tcdm_req_o [NB_TCDM_PORTS],
  input  logic [NB_TCDM_PORTS-1:0]      tcdm_gnt_i
);

  import stream_sink_pkg::*;

  sink_state_e cs, ns;

  logic                     start;          // Start accepted in this cycle.
  logic                     working;
  logic                     done_d;         // Transfer ends in this cycle.
  logic                     done_q;
  logic                     drained;        // Nothing left in lanes or FIFOs.
  logic [31:0]              gen_addr;
  logic                     gen_in_progress;
  logic                     gen_en;
  logic                     beat_valid;
  logic                     beat_ready;
  logic                     lanes_busy;
  tcdm_req_t                lane_req [NB_TCDM_PORTS];
  logic [NB_TCDM_PORTS-1:0] lane_gnt;
  logic [NB_TCDM_PORTS-1:0] fifo_empty;

  assign working = (cs == SINK_WORKING);
  assign start   = (cs == SINK_IDLE) & ctrl_i.req_start;
  assign drained = ~lanes_busy & (&fifo_empty);

  // The stream is only open while working and while beats remain to be counted.
  assign beat_valid     = stream_valid_i & working & gen_in_progress;
  assign stream_ready_o = beat_ready & working & gen_in_progress;
  assign gen_en         = stream_valid_i & stream_ready_o; // Advance on every transferred beat.

  assign flags_o.ready_start = (cs == SINK_IDLE);
  assign flags_o.done        = done_q;
  assign flags_o.in_progress = gen_in_progress;

  always_comb begin
    ns     = cs;
    done_d = 1'b0;
    case (cs)
      SINK_IDLE: begin
        if (start) begin
          ns = SINK_WORKING; // Pattern is loaded at the same edge.
        end
      end
      SINK_WORKING: begin
        // Wait for the last beat to be counted and for all stores to leave.
        if (!gen_in_progress && drained) begin
          ns     = SINK_IDLE;
          done_d = 1'b1;
        end
      end
      default: ns = SINK_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cs     <= SINK_IDLE;
      done_q <= 1'b0;
    end else if (clear_i) begin
      cs     <= SINK_IDLE;
      done_q <= 1'b0;
    end else begin
      cs     <= ns;
      done_q <= done_d; // The registered flag pulses for exactly one cycle.
    end
  end

  stream_addressgen #(
    .NB_TCDM_PORTS ( NB_TCDM_PORTS )
  ) i_addressgen (
    .clk_i         ( clk_i                  ),
    .rst_ni        ( rst_ni                 ),
    .clear_i       ( clear_i                ),
    .load_i        ( start                  ),
    .enable_i      ( gen_en                 ),
    .ctrl_i        ( ctrl_i.addressgen_ctrl ),
    .addr_o        ( gen_addr               ),
    .in_progress_o ( gen_in_progress        )
  );

  beat_splitter #(
    .NB_TCDM_PORTS ( NB_TCDM_PORTS )
  ) i_beat_splitter (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( clear_i    ),
    .beat_i       ( stream_i   ),
    .beat_valid_i ( beat_valid ),
    .beat_ready_o ( beat_ready ),
    .addr_i       ( gen_addr   ),
    .lane_o       ( lane_req   ),
    .lane_gnt_i   ( lane_gnt   ),
    .busy_o       ( lanes_busy )
  );

  // One store FIFO per memory port.
  for (genvar p = 0; p < NB_TCDM_PORTS; p++) begin : gen_port
    tcdm_store_fifo #(
      .FIFO_DEPTH ( TCDM_FIFO_DEPTH )
    ) i_store_fifo (
      .clk_i      ( clk_i         ),
      .rst_ni     ( rst_ni        ),
      .clear_i    ( clear_i       ),
      .push_i     ( lane_req[p]   ),
      .push_gnt_o ( lane_gnt[p]   ),
      .pop_o      ( tcdm_req_o[p] ),
      .pop_gnt_i  ( tcdm_gnt_i[p] ),
      .empty_o    ( fifo_empty[p] )
    );
  end

endmodule

`default_nettype wire

// ==== stream_sink_asserts.sv ====
/*
 * Concurrent checks on the store streamer.
 * Covers the memory request handshake, the done pulse and the
 * stream ready while idle. Bound into every stream_sink.
 */

`timescale 1ns/10ps
`default_nettype none

module stream_sink_asserts #(
  parameter int unsigned NB_TCDM_PORTS = 2
) (
  input logic                         clk_i,
  input logic                         rst_ni,
  input stream_sink_pkg::flags_sink_t flags_i,
  input logic                         stream_ready_i,
  input stream_sink_pkg::tcdm_req_t   tcdm_req_i [NB_TCDM_PORTS],
  input logic [NB_TCDM_PORTS-1:0]     tcdm_gnt_i,
  input stream_sink_pkg::sink_state_e state_i
);

  import stream_sink_pkg::*;

  for (genvar p = 0; p < NB_TCDM_PORTS; p++) begin : gen_port
    // A pending store must hold address, data and enables until memory takes it.
    req_stable_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tcdm_req_i[p].req && !tcdm_gnt_i[p] |=> $stable(tcdm_req_i[p]))
      else $error("port %0d request changed before its grant", p);
  end

  done_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    flags_i.done |=> !flags_i.done)
    else $error("done held for more than one cycle");

  idle_ready_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i == SINK_IDLE |-> !stream_ready_i)
    else $error("stream ready raised while idle");

endmodule

bind stream_sink stream_sink_asserts #(
  .NB_TCDM_PORTS ( NB_TCDM_PORTS )
) i_stream_sink_asserts (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .flags_i        ( flags_o        ),
  .stream_ready_i ( stream_ready_o ),
  .tcdm_req_i     ( tcdm_req_o     ),
  .tcdm_gnt_i     ( tcdm_gnt_i     ),
  .state_i        ( cs             )
);

`default_nettype wire

// ==== tb_stream_sink.sv ====
/*
 * Testbench for the store streamer.
 * Replays the patterns and beats of the golden file with random valid gaps,
 * grants memory requests at random and checks every store and the memory.
 */

`timescale 1ns/10ps
`default_nettype none

module tb_stream_sink;

  import stream_sink_pkg::*;

  localparam int NB_PORTS   = 2;
  localparam int FIFO_DEPTH = 2;
  localparam int GOLD_WORDS = 512;

  logic                clk_i;
  logic                rst_ni;
  logic                clear_i;
  ctrl_sink_t          ctrl_i;
  flags_sink_t         flags_o;
  stream_word_t        stream_i [NB_PORTS];
  logic                stream_valid_i;
  logic                stream_ready_o;
  tcdm_req_t           tcdm_req_o [NB_PORTS];
  logic [NB_PORTS-1:0] tcdm_gnt_i;

  logic [31:0] golden [GOLD_WORDS];
  logic [7:0]  mem [int unsigned];     // Bytes the DUT has written.
  logic [7:0]  exp_mem [int unsigned]; // Bytes the transfers should leave behind.
  tcdm_req_t   exp_st [NB_PORTS][256]; // Expected stores per port, in issue order.
  int          wr_idx [NB_PORTS];
  int          rd_idx [NB_PORTS];
  logic [31:0] lcg_state = 32'd2;
  logic [2:0]  gap_roll;               // Drawn at each rising edge for the driver.
  int          errors, store_cnt, test_stores, done_cnt, cycle_cnt, cycle_limit;
  bit          started;

  stream_sink #(
    .NB_TCDM_PORTS   ( NB_PORTS   ),
    .TCDM_FIFO_DEPTH ( FIFO_DEPTH )
  ) stream_sink_inst (
    .clk_i, .rst_ni, .clear_i, .ctrl_i, .flags_o, .stream_i,
    .stream_valid_i, .stream_ready_o, .tcdm_req_o, .tcdm_gnt_i
  );

  always #5 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Untouched memory reads back a pattern built from every address byte.
  function automatic logic [7:0] fill_byte(logic [31:0] a);
    return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
  endfunction

  function automatic logic [7:0] mem_byte(logic [31:0] a);
    if (mem.exists(a))
      return mem[a];
    return fill_byte(a);
  endfunction

  function automatic logic [7:0] expected_byte(logic [31:0] a);
    if (exp_mem.exists(a))
      return exp_mem[a];
    return fill_byte(a);
  endfunction

  // Beat k sits in line k/ll at the stride and word p sits 4*p bytes into the beat.
  function automatic logic [31:0] beat_addr(logic [31:0] base, int k, int ll,
                                            logic [31:0] stride, int p);
    return base + 32'(k / ll) * stride + 32'((k % ll) * 4 * NB_PORTS + 4 * p);
  endfunction

  task automatic report_error(string msg);
    errors++;
    $display("error at %0t: %s", $time, msg);
  endtask

  // All random draws happen here, once per rising edge.
  always @(posedge clk_i) begin
    logic [31:0] rnd;
    rnd = lcg_next();
    gap_roll = rnd[30:28];
    #1;
    for (int p = 0; p < NB_PORTS; p++) begin
      tcdm_gnt_i[p] = (rnd[20 + 4 * p +: 2] != 2'b00); // Grant about three in four cycles.
    end
  end

  // The memory model and the store checks sample at the falling edge.
  always @(negedge clk_i) begin
    tcdm_req_t want;
    if (rst_ni) begin
      if (!started && (flags_o.done || tcdm_req_o[0].req || tcdm_req_o[1].req))
        report_error("req or done seen before the first start");
      for (int p = 0; p < NB_PORTS; p++) begin
        if (tcdm_req_o[p].req && tcdm_gnt_i[p]) begin
          store_cnt++;
          test_stores++;
          if (rd_idx[p] == wr_idx[p]) begin
            report_error($sformatf("port %0d store to %h with no beat pending", p,
                                   tcdm_req_o[p].addr));
          end else begin
            want = exp_st[p][rd_idx[p] % 256];
            if (tcdm_req_o[p].addr !== want.addr || tcdm_req_o[p].data !== want.data ||
                tcdm_req_o[p].be !== want.be)
              report_error($sformatf("port %0d store %h/%h/%h, expected %h/%h/%h", p,
                tcdm_req_o[p].addr, tcdm_req_o[p].data, tcdm_req_o[p].be,
                want.addr, want.data, want.be));
            rd_idx[p]++;
          end
          for (int b = 0; b < 4; b++) begin
            if (tcdm_req_o[p].be[b])
              mem[tcdm_req_o[p].addr + 32'(b)] = tcdm_req_o[p].data[8*b +: 8];
          end
        end
      end
      if (flags_o.done) begin
        done_cnt++;
        if (!flags_o.ready_start) report_error("ready_start low while done is high");
        for (int p = 0; p < NB_PORTS; p++) begin
          if (rd_idx[p] != wr_idx[p])
            report_error($sformatf("done with %0d stores missing on port %0d",
                                   wr_idx[p] - rd_idx[p], p));
        end
      end
    end
  end

  // Aborts a run that stops making progress.
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** FAILED ***");
      $finish;
    end
  end

  initial begin
    int           idx, n, ll, density, tests, beats, nlines, span;
    logic [31:0]  base, stride, a;
    stream_word_t beat [NB_PORTS];
    tcdm_req_t    st;
    bit           accepted;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    clear_i        = 1'b0;
    ctrl_i         = '0;
    stream_valid_i = 1'b0;
    tcdm_gnt_i     = '0;
    for (int p = 0; p < NB_PORTS; p++) begin
      stream_i[p] = '0;
      wr_idx[p]   = 0;
      rd_idx[p]   = 0;
    end
    $readmemh("stream_sink_golden.txt", golden);
    idx   = 0;
    beats = 0;
    while (idx < GOLD_WORDS - 5 && golden[idx + 1] != 32'd0) begin // Count beats for the limit.
      beats += int'(golden[idx + 1]);
      idx   += 5 + 4 * int'(golden[idx + 1]);
    end
    cycle_limit = 200 * beats + 20;

    repeat (8) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    @(negedge clk_i);
    if (!flags_o.ready_start || flags_o.done || flags_o.in_progress || stream_ready_o)
      report_error("flags after reset are not ready_start only");

    idx   = 0;
    tests = 0;
    while (idx < GOLD_WORDS - 5 && golden[idx + 1] != 32'd0) begin
      base    = golden[idx];
      n       = int'(golden[idx + 1]);
      ll      = int'(golden[idx + 2]);
      stride  = golden[idx + 3];
      density = int'(golden[idx + 4]);
      idx    += 5;
      @(posedge clk_i);
      #1;
      ctrl_i.addressgen_ctrl.base_addr   = base;
      ctrl_i.addressgen_ctrl.trans_size  = 16'(n);
      ctrl_i.addressgen_ctrl.line_length = 16'(ll);
      ctrl_i.addressgen_ctrl.line_stride = stride;
      ctrl_i.req_start = 1'b1; // The idle sink takes the start at the next edge.
      started          = 1'b1;
      test_stores      = 0;
      for (int k = 0; k < n; k++) begin
        for (int p = 0; p < NB_PORTS; p++) begin
          beat[p].data = golden[idx + p];
          beat[p].strb = golden[idx + 2 + p][3:0];
        end
        idx     += 4;
        accepted = 1'b0;
        while (!accepted) begin
          @(posedge clk_i);
          #1;
          ctrl_i.req_start = 1'b0;
          stream_valid_i   = (int'(gap_roll) >= density); // Random gap in valid.
          for (int p = 0; p < NB_PORTS; p++) stream_i[p] = stream_valid_i ? beat[p] : '0;
          @(negedge clk_i);
          if (!flags_o.in_progress)
            report_error("in_progress low while beats remain");
          if (stream_valid_i && stream_ready_o) begin
            accepted = 1'b1; // Beat transfers at the coming edge.
            for (int p = 0; p < NB_PORTS; p++) begin
              st.req  = 1'b1;
              st.addr = beat_addr(base, k, ll, stride, p);
              st.data = beat[p].data;
              st.be   = beat[p].strb;
              exp_st[p][wr_idx[p] % 256] = st;
              wr_idx[p]++;
              for (int b = 0; b < 4; b++) begin
                if (st.be[b]) exp_mem[st.addr + 32'(b)] = st.data[8*b +: 8];
              end
            end
          end
        end
      end
      @(posedge clk_i);
      #1 stream_valid_i = 1'b0;
      if (flags_o.in_progress)
        report_error("in_progress still high after the last beat");
      do @(negedge clk_i); while (!flags_o.done);
      tests++;
      if (test_stores != NB_PORTS * n)
        report_error($sformatf("test %0d granted %0d stores, expected %0d", tests,
                               test_stores, NB_PORTS * n));
      nlines = (n + ll - 1) / ll;
      span   = (nlines - 1) * int'(stride) + ll * 4 * NB_PORTS;
      for (int off = -8; off < span + 8; off++) begin // Includes the gaps between lines.
        a = base + 32'(off);
        if (mem_byte(a) !== expected_byte(a))
          report_error($sformatf("memory byte %h is %h, expected %h", a, mem_byte(a),
                                 expected_byte(a)));
      end
    end

    if (tests == 0) begin
      errors++;
      $display("The golden file holds no test.");
    end
    repeat (4) @(posedge clk_i); // Leaves room for a stray extra done.
    if (done_cnt != tests)
      report_error($sformatf("%0d done pulses for %0d tests", done_cnt, tests));
    $display("Summary: %0d tests, %0d stores, %0d done pulses, %0d errors",
             tests, store_cnt, done_cnt, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== stream_sink.f ====
stream_sink_pkg.sv
stream_addressgen.sv
beat_splitter.sv
tcdm_store_fifo.sv
stream_sink.sv
stream_sink_asserts.sv
tb_stream_sink.sv

// ==== Makefile ====
# Verilator flow for the store streamer.
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TB_TOP    := tb_stream_sink
RTL_TOP   := stream_sink
FLIST     := stream_sink.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FLIST) --top-module $(RTL_TOP)

# The run passes only if the testbench printed the pass line.
sim:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

// ==== stream_sink_golden.txt ====
// Config line: base trans_size line_length line_stride stall_density (gap when roll 0..7 < density).
// Beat line: word0 word1 strobe0 strobe1. A config line with trans_size 0 ends the list.
// Linear transfer, full strobes.
00001000 4 4 00000020 0
11110000 11110001 f f
22220000 22220001 f f
33330000 33330001 f f
44440000 44440001 f f
// Two-dimensional pattern, lines of two beats placed 0x40 apart.
00002000 6 2 00000040 0
a0a00000 a0a00001 f f
a1a10000 a1a10001 f f
a2a20000 a2a20001 f f
a3a30000 a3a30001 f f
a4a40000 a4a40001 f f
a5a50000 a5a50001 f f
// Partial strobes over pre-filled words.
00003000 3 3 00000000 1
deadbeef cafef00d 3 c
01234567 89abcdef 5 a
76543210 fedcba98 0 9
// Heavy valid gaps, two lines of four beats 0x30 apart.
00004000 8 4 00000030 5
b0000000 b0000001 f f
b1000000 b1000001 e 7
b2000000 b2000001 f f
b3000000 b3000001 1 8
b4000000 b4000001 f f
b5000000 b5000001 f f
b6000000 b6000001 6 f
b7000000 b7000001 f f
// End of list.
00000000 0 0 00000000 0
